/* host_chan_avalon_top.sv */
`timescale 1ns/1ps

// Host channel adapter top level
// Read reorder path and MMIO bridge side by side, sharing the host transmit channel
module host_chan_avalon_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_req_valid,
    output logic                        rd_req_ready,
    input  host_chan_pkg::mem_rd_req_t  rd_req,
    output logic                        rd_rsp_valid,
    input  logic                        rd_rsp_ready,
    output host_chan_pkg::mem_rd_rsp_t  rd_rsp,
    input  logic                        host_rx_valid,
    input  host_chan_pkg::host_rx_rsp_t host_rx,
    input  logic                        mmio_in_valid,
    output logic                        mmio_in_ready,
    input  host_chan_pkg::mmio_req_t    mmio_in,
    output logic                        host_tx_valid,
    input  logic                        host_tx_ready,
    output host_chan_pkg::host_tx_t     host_tx,
    output logic                        av_req_valid,
    input  logic                        av_req_ready,
    output host_chan_pkg::av_req_t      av_req,
    input  logic                        av_rsp_valid,
    input  host_chan_pkg::av_rsp_t      av_rsp
);

    import host_chan_pkg::*;

    // ========================================
    // Internal streams
    // ========================================

    // Tagged read requests and MMIO read data heading for the arbiter
    logic     rob_tx_valid, rob_tx_ready;
    host_tx_t rob_tx;
    logic     br_tx_valid, br_tx_ready;
    host_tx_t br_tx;

    // Merged transmit beat ahead of its output stage
    logic     arb_valid, arb_ready;
    host_tx_t arb_out;

    // Ordered read data and Avalon requests ahead of their output stages
    logic        rob_rsp_valid, rob_rsp_ready;
    mem_rd_rsp_t rob_rsp;
    logic        br_av_valid, br_av_ready;
    av_req_t     br_av;

    rd_rob rob_i (
        .clk, .rst_n,
        .req_valid(rd_req_valid), .req_ready(rd_req_ready), .req(rd_req),
        .tx_valid(rob_tx_valid), .tx_ready(rob_tx_ready), .tx(rob_tx),
        .host_rx_valid, .host_rx,
        .rsp_valid(rob_rsp_valid), .rsp_ready(rob_rsp_ready), .rsp(rob_rsp)
    );

    mmio_avalon_bridge bridge_i (
        .clk, .rst_n,
        .mmio_valid(mmio_in_valid), .mmio_ready(mmio_in_ready), .mmio(mmio_in),
        .av_req_valid(br_av_valid), .av_req_ready(br_av_ready), .av_req(br_av),
        .av_rsp_valid, .av_rsp,
        .tx_valid(br_tx_valid), .tx_ready(br_tx_ready), .tx(br_tx)
    );

    host_tx_arb arb_i (
        .clk, .rst_n,
        .rd_valid(rob_tx_valid), .rd_ready(rob_tx_ready), .rd(rob_tx),
        .mmio_valid(br_tx_valid), .mmio_ready(br_tx_ready), .mmio(br_tx),
        .out_valid(arb_valid), .out_ready(arb_ready), .out(arb_out)
    );

    // Output stages, one per outgoing stream
    pipe_reg_slice #(.payload_t(host_tx_t)) tx_slice_i (
        .clk, .rst_n,
        .in_valid(arb_valid), .in_ready(arb_ready), .in_data(arb_out),
        .out_valid(host_tx_valid), .out_ready(host_tx_ready), .out_data(host_tx)
    );

    pipe_reg_slice #(.payload_t(mem_rd_rsp_t)) rsp_slice_i (
        .clk, .rst_n,
        .in_valid(rob_rsp_valid), .in_ready(rob_rsp_ready), .in_data(rob_rsp),
        .out_valid(rd_rsp_valid), .out_ready(rd_rsp_ready), .out_data(rd_rsp)
    );

    pipe_reg_slice #(.payload_t(av_req_t)) av_slice_i (
        .clk, .rst_n,
        .in_valid(br_av_valid), .in_ready(br_av_ready), .in_data(br_av),
        .out_valid(av_req_valid), .out_ready(av_req_ready), .out_data(av_req)
    );

endmodule

/* host_chan_cfg.svh */
`ifndef HOST_CHAN_CFG_SVH
`define HOST_CHAN_CFG_SVH

// Sizes shared by the host channel adapter and its testbench

// Host physical address width of an accelerator read
`define HC_ADDR_W 32

// One data word on every path
`define HC_DATA_W 64

// Read tag width, one tag per reorder-buffer slot
`define HC_TAG_W 3

// Reorder-buffer depth follows from the tag width
`define HC_ROB_DEPTH (1 << `HC_TAG_W)

// MMIO register address width on the Avalon side
`define HC_MMIO_ADDR_W 16

// Host MMIO transaction id width
`define HC_TID_W 9

// MMIO reads the bridge may hold ids for at once
`define HC_MMIO_RD_MAX 4

`endif

/* host_chan_pkg.sv */
`include "host_chan_cfg.svh"

package host_chan_pkg;

    // ========================================
    // Accelerator read path
    // ========================================

    // Read request issued by the accelerator, one word address
    typedef struct packed {
        logic [`HC_ADDR_W-1:0] addr;
    } mem_rd_req_t;

    // Read data handed back to the accelerator in issue order
    typedef struct packed {
        logic [`HC_DATA_W-1:0] data;
    } mem_rd_rsp_t;

    // Host reply, which may come back in any order
    typedef struct packed {
        logic [`HC_TAG_W-1:0]  tag;
        logic [`HC_DATA_W-1:0] data;
    } host_rx_rsp_t;

    // ========================================
    // MMIO path
    // ========================================

    // Host MMIO request; data is ignored for a read
    typedef struct packed {
        logic                       wr;
        logic [`HC_TID_W-1:0]       tid;
        logic [`HC_MMIO_ADDR_W-1:0] addr;
        logic [`HC_DATA_W-1:0]      data;
    } mmio_req_t;

    // Avalon slave request toward the accelerator registers
    typedef struct packed {
        logic                       wr;
        logic [`HC_MMIO_ADDR_W-1:0] addr;
        logic [`HC_DATA_W-1:0]      wdata;
    } av_req_t;

    // Avalon readdata, returned in request order
    typedef struct packed {
        logic [`HC_DATA_W-1:0] rdata;
    } av_rsp_t;

    // ========================================
    // Host transmit channel
    // ========================================

    typedef enum logic {
        RD_REQ   = 1'b0,
        MMIO_RSP = 1'b1
    } host_tx_kind_t;

    // The id holds a read tag for RD_REQ and a tid for MMIO_RSP
    typedef struct packed {
        host_tx_kind_t         kind;
        logic [`HC_TID_W-1:0]  id;
        logic [`HC_ADDR_W-1:0] addr;
        logic [`HC_DATA_W-1:0] data;
    } host_tx_t;

endpackage

/* host_tx_arb.sv */
`timescale 1ns/1ps

// Two-way round-robin merge onto the host transmit channel
module host_tx_arb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rd_valid,
    output logic                    rd_ready,
    input  host_chan_pkg::host_tx_t rd,
    input  logic                    mmio_valid,
    output logic                    mmio_ready,
    input  host_chan_pkg::host_tx_t mmio,
    output logic                    out_valid,
    input  logic                    out_ready,
    output host_chan_pkg::host_tx_t out
);

    // Set when the MMIO side has priority in a tie
    logic prio_mmio;

    logic grant_rd;
    logic grant_mmio;

    // The selection is combinational, only the priority flag is stored
    assign grant_rd   = rd_valid && (!mmio_valid || !prio_mmio);
    assign grant_mmio = mmio_valid && (!rd_valid || prio_mmio);

    assign out_valid  = rd_valid || mmio_valid;
    assign out        = grant_mmio ? mmio : rd;
    assign rd_ready   = out_ready && grant_rd;
    assign mmio_ready = out_ready && grant_mmio;

    // After a transfer the other source wins the next tie
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_mmio <= 1'b0;
        end else if (out_valid && out_ready) begin
            prio_mmio <= grant_rd;
        end
    end

    a_one_grant : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rd_ready && mmio_ready)
    ) else $error("host_tx_arb: both inputs granted in one cycle");

    // A read passed over for an MMIO beat goes first on the next cycle
    a_rd_no_starve : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid && mmio_valid && mmio_ready |=> grant_rd
    ) else $error("host_tx_arb: read source passed over twice");

    // Same guarantee for the MMIO side
    a_mmio_no_starve : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid && mmio_valid && rd_ready |=> grant_mmio
    ) else $error("host_tx_arb: MMIO source passed over twice");

endmodule

/* mmio_avalon_bridge.sv */
`timescale 1ns/1ps

`include "host_chan_cfg.svh"

// Host MMIO to Avalon slave bridge
// Reads keep their tid in a small FIFO whose slots also hold the returned data
module mmio_avalon_bridge (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mmio_valid,
    output logic                     mmio_ready,
    input  host_chan_pkg::mmio_req_t mmio,
    output logic                     av_req_valid,
    input  logic                     av_req_ready,
    output host_chan_pkg::av_req_t   av_req,
    input  logic                     av_rsp_valid,
    input  host_chan_pkg::av_rsp_t   av_rsp,
    output logic                     tx_valid,
    input  logic                     tx_ready,
    output host_chan_pkg::host_tx_t  tx
);

    import host_chan_pkg::*;

    localparam int PW = $clog2(`HC_MMIO_RD_MAX);

    // ========================================
    // Read id FIFO with response storage
    // ========================================

    // Push on read accept, fill on Avalon data, pop on transmit
    logic [PW:0]   wr_ptr;
    logic [PW:0]   fill_ptr;
    logic [PW:0]   head_ptr;
    logic [PW-1:0] head_idx;
    logic [PW:0]   in_flight;
    logic [PW:0]   awaiting;
    logic          rd_full;

    logic [`HC_TID_W-1:0]      tid_q  [`HC_MMIO_RD_MAX];
    logic [`HC_DATA_W-1:0]     data_q [`HC_MMIO_RD_MAX];
    logic [`HC_MMIO_RD_MAX-1:0] dvld;

    logic live;
    logic mmio_fire;
    logic rd_push;
    logic tx_fire;

    assign head_idx  = head_ptr[PW-1:0];
    assign in_flight = wr_ptr - head_ptr;
    assign awaiting  = wr_ptr - fill_ptr;
    assign rd_full   = (in_flight == (PW+1)'(`HC_MMIO_RD_MAX));

    // Writes only need the Avalon register free, reads also need an id slot
    assign mmio_ready = live && (!av_req_valid || av_req_ready) && (mmio.wr || !rd_full);
    assign mmio_fire  = mmio_valid && mmio_ready;
    assign rd_push    = mmio_fire && !mmio.wr;

    // The head slot is offered as soon as its data has landed
    assign tx_valid = dvld[head_idx];
    assign tx_fire  = tx_valid && tx_ready;

    always_comb begin
        tx.kind = MMIO_RSP;
        tx.id   = tid_q[head_idx];
        tx.addr = '0;
        tx.data = data_q[head_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live         <= 1'b0;
            av_req_valid <= 1'b0;
            wr_ptr       <= '0;
            fill_ptr     <= '0;
            head_ptr     <= '0;
            dvld         <= '0;
        end else begin
            live <= 1'b1;

            if (mmio_fire) begin
                av_req_valid <= 1'b1;
            end else if (av_req_ready) begin
                av_req_valid <= 1'b0;
            end

            if (rd_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            // A filling slot is never the one being popped
            if (tx_fire) begin
                dvld[head_idx] <= 1'b0;
                head_ptr       <= head_ptr + 1'b1;
            end
            if (av_rsp_valid) begin
                dvld[fill_ptr[PW-1:0]] <= 1'b1;
                fill_ptr               <= fill_ptr + 1'b1;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (mmio_fire) begin
            av_req.wr    <= mmio.wr;
            av_req.addr  <= mmio.addr;
            av_req.wdata <= mmio.data;
        end
        if (rd_push) begin
            tid_q[wr_ptr[PW-1:0]] <= mmio.tid;
        end
        if (av_rsp_valid) begin
            data_q[fill_ptr[PW-1:0]] <= av_rsp.rdata;
        end
    end

    // Readdata must belong to a read that was sent and is still unanswered
    a_rsp_has_tid : assert property (
        @(posedge clk) disable iff (!rst_n)
        av_rsp_valid |-> (awaiting != '0)
    ) else $error("mmio_avalon_bridge: Avalon readdata with no read waiting");

endmodule

/* pipe_reg_slice.sv */
`timescale 1ns/1ps

// One-entry register stage on a valid/ready stream
// Output valid and data come straight from flops, so the valid path is cut
module pipe_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Low for the first cycle after reset so no beat is taken early
    logic live;

    logic in_fire;

    // Room exists when empty or when the held beat leaves this cycle
    assign in_ready = live && (!out_valid || out_ready);
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            live <= 1'b1;
            if (in_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Payload only moves on an accepted beat
    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= in_data;
        end
    end

    // A stalled beat stays offered and unchanged until it is taken
    a_hold_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pipe_reg_slice: held beat changed while stalled");

endmodule

/* project.f */
+incdir+.
host_chan_pkg.sv
pipe_reg_slice.sv
rd_rob.sv
mmio_avalon_bridge.sv
host_tx_arb.sv
host_chan_avalon_top.sv
tb_checker.sv
tb_host_chan.sv

/* rd_rob.sv */
`timescale 1ns/1ps

`include "host_chan_cfg.svh"

// Read reorder buffer
// Tags go out in a circular sequence and data returns in that same order
module rd_rob (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  host_chan_pkg::mem_rd_req_t req,
    output logic                       tx_valid,
    input  logic                       tx_ready,
    output host_chan_pkg::host_tx_t    tx,
    input  logic                       host_rx_valid,
    input  host_chan_pkg::host_rx_rsp_t host_rx,
    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output host_chan_pkg::mem_rd_rsp_t rsp
);

    import host_chan_pkg::*;

    // ========================================
    // Pointers and slot state
    // ========================================

    // Pointers carry one extra wrap bit to tell full from empty
    logic [`HC_TAG_W:0]   iss_ptr;
    logic [`HC_TAG_W:0]   ret_ptr;
    logic [`HC_TAG_W-1:0] iss_idx;
    logic [`HC_TAG_W-1:0] ret_idx;
    logic [`HC_TAG_W:0]   occupancy;
    logic                 rob_full;

    // Reply data and a flag per slot telling that the host has answered
    logic [`HC_DATA_W-1:0]    data_q [`HC_ROB_DEPTH];
    logic [`HC_ROB_DEPTH-1:0] slot_vld;

    logic live;
    logic req_fire;
    logic retire;

    // Distance of a reply's tag from the oldest outstanding slot
    logic [`HC_TAG_W-1:0] rx_offset;

    assign iss_idx   = iss_ptr[`HC_TAG_W-1:0];
    assign ret_idx   = ret_ptr[`HC_TAG_W-1:0];
    assign occupancy = iss_ptr - ret_ptr;
    assign rob_full  = (occupancy == (`HC_TAG_W+1)'(`HC_ROB_DEPTH));
    assign rx_offset = host_rx.tag - ret_idx;

    // A new read needs a free tag and room in the outgoing request register
    assign req_ready = live && !rob_full && (!tx_valid || tx_ready);
    assign req_fire  = req_valid && req_ready;

    // The oldest slot retires once its data is in and the output has room
    assign retire = slot_vld[ret_idx] && (!rsp_valid || rsp_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live      <= 1'b0;
            iss_ptr   <= '0;
            ret_ptr   <= '0;
            slot_vld  <= '0;
            tx_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            live <= 1'b1;

            // Request side, the tagged read is offered to the arbiter next cycle
            if (req_fire) begin
                iss_ptr  <= iss_ptr + 1'b1;
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end

            // Clear before set, a reply always targets a different slot
            if (retire) begin
                slot_vld[ret_idx] <= 1'b0;
                ret_ptr           <= ret_ptr + 1'b1;
            end
            if (host_rx_valid) begin
                slot_vld[host_rx.tag] <= 1'b1;
            end

            if (retire) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // ========================================
    // Payload registers
    // ========================================

    always_ff @(posedge clk) begin
        if (host_rx_valid) begin
            data_q[host_rx.tag] <= host_rx.data;
        end
        if (req_fire) begin
            tx.kind <= RD_REQ;
            tx.id   <= {{(`HC_TID_W-`HC_TAG_W){1'b0}}, iss_idx};
            tx.addr <= req.addr;
            tx.data <= '0;
        end
        if (retire) begin
            rsp.data <= data_q[ret_idx];
        end
    end

    // The host may only answer a tag that is issued and not yet answered
    a_rx_outstanding : assert property (
        @(posedge clk) disable iff (!rst_n)
        host_rx_valid |-> ({1'b0, rx_offset} < occupancy) && !slot_vld[host_rx.tag]
    ) else $error("rd_rob: host reply for a tag that is not outstanding");

    // Issue never runs more than a full buffer ahead of retire
    a_no_overrun : assert property (
        @(posedge clk) disable iff (!rst_n)
        occupancy <= (`HC_TAG_W+1)'(`HC_ROB_DEPTH)
    ) else $error("rd_rob: issue pointer overran the retire pointer");

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_host_chan -Mdir obj_dir

out=$(./obj_dir/Vtb_host_chan || true)
echo "$out"

if grep -q "RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1

/* tb_checker.sv */
`timescale 1ns/1ps

`include "host_chan_cfg.svh"

// Watches the DUT ports and compares every outgoing beat with the expected one
module tb_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_req_valid,
    input  logic                        rd_req_ready,
    input  host_chan_pkg::mem_rd_req_t  rd_req,
    input  logic                        rd_rsp_valid,
    input  logic                        rd_rsp_ready,
    input  host_chan_pkg::mem_rd_rsp_t  rd_rsp,
    input  logic                        host_rx_valid,
    input  logic                        mmio_in_valid,
    input  logic                        mmio_in_ready,
    input  host_chan_pkg::mmio_req_t    mmio_in,
    input  logic                        host_tx_valid,
    input  logic                        host_tx_ready,
    input  host_chan_pkg::host_tx_t     host_tx,
    input  logic                        av_req_valid,
    input  logic                        av_req_ready,
    input  host_chan_pkg::av_req_t      av_req,
    output int                          value_errs,
    output int                          proto_errs,
    output logic                        drained
);

    import host_chan_pkg::*;

    // ========================================
    // Scoreboards
    // ========================================

    logic [`HC_DATA_W-1:0] exp_rd_data   [$];
    logic [`HC_ADDR_W-1:0] exp_rd_addr   [$];
    logic [`HC_TID_W-1:0]  exp_tid       [$];
    logic [`HC_DATA_W-1:0] exp_mmio_data [$];
    av_req_t               exp_av        [$];

    // Register contents as the host's writes leave them
    logic [`HC_DATA_W-1:0] shadow [64];

    int rd_issued  = 0;
    int rd_replied = 0;
    int rd_tx_seen = 0;

    // Last cycle's stall state per output stream
    logic        tx_held  = 1'b0;
    logic        rsp_held = 1'b0;
    logic        av_held  = 1'b0;
    host_tx_t    tx_last;
    mem_rd_rsp_t rsp_last;
    av_req_t     av_last;
    av_req_t     av_exp;

    initial begin
        value_errs = 0;
        proto_errs = 0;
        drained    = 1'b1;
    end

    // Host memory contents, the address folded with a fixed constant
    function automatic logic [`HC_DATA_W-1:0] mem_data(input logic [`HC_ADDR_W-1:0] addr);
        return {addr ^ 32'h5A17_C3E9, addr * 32'h9E37_79B9} ^ 64'h0123_4567_89AB_CDEF;
    endfunction

    task automatic compare_word(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            value_errs++;
        end
    endtask

    task automatic report_protocol(input string what);
        $display("protocol error at %0t: %s", $time, what);
        proto_errs++;
    endtask

    // RD_REQ beats leave in issue order with tags counting round the buffer
    task automatic check_tx_beat();
        if (host_tx.kind == RD_REQ) begin
            if (exp_rd_addr.size() == 0) begin
                report_protocol("RD_REQ beat on host_tx with no read issued");
            end else begin
                compare_word("host_tx.addr", exp_rd_addr.pop_front(), host_tx.addr);
                compare_word("host_tx.id", rd_tx_seen % `HC_ROB_DEPTH, host_tx.id);
                rd_tx_seen++;
            end
        end else if (exp_tid.size() == 0) begin
            report_protocol("MMIO_RSP beat on host_tx with no MMIO read outstanding");
        end else begin
            compare_word("host_tx.id", exp_tid.pop_front(), host_tx.id);
            compare_word("host_tx.data", exp_mmio_data.pop_front(), host_tx.data);
        end
    endtask

    // ========================================
    // Port monitor
    // ========================================

    always @(posedge clk) begin
        if (!rst_n) begin
            tx_held  = 1'b0;
            rsp_held = 1'b0;
            av_held  = 1'b0;
        end else begin
            // Unanswered reads are a lower bound on the tags in use
            if (rd_req_valid && rd_req_ready) begin
                if (rd_issued - rd_replied >= `HC_ROB_DEPTH) begin
                    report_protocol("rd_req accepted while all tags were outstanding");
                end
                exp_rd_data.push_back(mem_data(rd_req.addr));
                exp_rd_addr.push_back(rd_req.addr);
                rd_issued++;
            end
            if (host_rx_valid) begin
                rd_replied++;
            end
            if (host_tx_valid && host_tx_ready) begin
                check_tx_beat();
            end
            if (rd_rsp_valid && rd_rsp_ready) begin
                if (exp_rd_data.size() == 0) begin
                    report_protocol("rd_rsp beat with no read outstanding");
                end else begin
                    compare_word("rd_rsp.data", exp_rd_data.pop_front(), rd_rsp.data);
                end
            end

            // The shadow moves at mmio_in, which is also the order the slave sees
            if (mmio_in_valid && mmio_in_ready) begin
                exp_av.push_back('{wr: mmio_in.wr, addr: mmio_in.addr, wdata: mmio_in.data});
                if (mmio_in.wr) begin
                    shadow[mmio_in.addr[5:0]] = mmio_in.data;
                end else begin
                    exp_tid.push_back(mmio_in.tid);
                    exp_mmio_data.push_back(shadow[mmio_in.addr[5:0]]);
                end
            end
            if (av_req_valid && av_req_ready) begin
                if (exp_av.size() == 0) begin
                    report_protocol("av_req beat with no MMIO request behind it");
                end else begin
                    av_exp = exp_av.pop_front();
                    compare_word("av_req.wr", av_exp.wr, av_req.wr);
                    compare_word("av_req.addr", av_exp.addr, av_req.addr);
                    if (av_exp.wr) begin
                        compare_word("av_req.wdata", av_exp.wdata, av_req.wdata);
                    end
                end
            end

            // A stalled beat must still be there, unchanged, one cycle on
            if (tx_held && (!host_tx_valid || host_tx !== tx_last)) begin
                report_protocol("host_tx beat changed or vanished while stalled");
            end
            if (rsp_held && (!rd_rsp_valid || rd_rsp !== rsp_last)) begin
                report_protocol("rd_rsp beat changed or vanished while stalled");
            end
            if (av_held && (!av_req_valid || av_req !== av_last)) begin
                report_protocol("av_req beat changed or vanished while stalled");
            end
            tx_held  = host_tx_valid && !host_tx_ready;
            rsp_held = rd_rsp_valid && !rd_rsp_ready;
            av_held  = av_req_valid && !av_req_ready;
            tx_last  = host_tx;
            rsp_last = rd_rsp;
            av_last  = av_req;

            drained = exp_rd_data.size() == 0 && exp_rd_addr.size() == 0 &&
                      exp_tid.size() == 0 && exp_av.size() == 0;
        end
    end

endmodule

/* tb_host_chan.sv */
`timescale 1ns/1ps

`include "host_chan_cfg.svh"

module tb_host_chan;

    import host_chan_pkg::*;

    // Operation counts per phase set the watchdog limit
    localparam int N_P1     = 16;
    localparam int N_P2     = 10;
    localparam int N_P3     = 32;
    localparam int N_P4     = 80;
    localparam int N_OPS    = N_P1 + N_P2 + N_P3 + N_P4;
    localparam int WD_LIMIT = N_OPS * 40 + 200;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         rd_req_valid;
    logic         rd_req_ready;
    mem_rd_req_t  rd_req;
    logic         rd_rsp_valid;
    logic         rd_rsp_ready;
    mem_rd_rsp_t  rd_rsp;
    logic         host_rx_valid;
    host_rx_rsp_t host_rx;
    logic         mmio_in_valid;
    logic         mmio_in_ready;
    mmio_req_t    mmio_in;
    logic         host_tx_valid;
    logic         host_tx_ready;
    host_tx_t     host_tx;
    logic         av_req_valid;
    logic         av_req_ready;
    av_req_t      av_req;
    logic         av_rsp_valid;
    av_rsp_t      av_rsp;

    int   value_errs;
    int   proto_errs;
    logic drained;

    integer seed = 90;

    // Knobs the stimulus uses to shape traffic
    logic hold_replies  = 1'b0;
    logic stall_outputs = 1'b0;
    logic [`HC_TID_W-1:0] next_tid = '0;

    host_chan_avalon_top dut_i (.*);

    tb_checker chk_i (.*);

    always #5 clk = ~clk;

    // ========================================
    // Output ready drivers
    // ========================================

    // Each ready drops about one cycle in four while stalls are on
    always @(posedge clk) begin
        if (stall_outputs) begin
            host_tx_ready <= ($random(seed) & 3) != 0;
            rd_rsp_ready  <= ($random(seed) & 3) != 0;
            av_req_ready  <= ($random(seed) & 3) != 0;
        end else begin
            host_tx_ready <= 1'b1;
            rd_rsp_ready  <= 1'b1;
            av_req_ready  <= 1'b1;
        end
    end

    // ========================================
    // Host model
    // ========================================

    // Reads seen on host_tx wait here until the host answers them
    logic [`HC_TAG_W-1:0]  pend_tag  [$];
    logic [`HC_ADDR_W-1:0] pend_addr [$];
    int pick;

    // Picks a random pending read, so replies come back shuffled
    always @(posedge clk) begin
        host_rx_valid <= 1'b0;
        if (rst_n) begin
            if (host_tx_valid && host_tx_ready && host_tx.kind == RD_REQ) begin
                pend_tag.push_back(host_tx.id[`HC_TAG_W-1:0]);
                pend_addr.push_back(host_tx.addr);
            end
            if (!hold_replies && pend_tag.size() > 0 && ($random(seed) & 1) != 0) begin
                pick = $unsigned($random(seed)) % pend_tag.size();
                host_rx_valid <= 1'b1;
                host_rx.tag   <= pend_tag[pick];
                host_rx.data  <= chk_i.mem_data(pend_addr[pick]);
                pend_tag.delete(pick);
                pend_addr.delete(pick);
            end
        end
    end

    // ========================================
    // Avalon slave model
    // ========================================

    logic [`HC_DATA_W-1:0] regs [64];
    logic [`HC_DATA_W-1:0] rsp_data [$];
    int rsp_due [$];
    int cycle = 0;
    int last_due = 0;
    int due;

    // Every register starts with a value built from its full index
    initial begin
        for (int i = 0; i < 64; i++) begin
            regs[i] = {32'h0F0F_0000 + 32'(i), ~(32'(i) * 32'h0101_0101)};
        end
    end

    // Each read is answered in order 1 to 4 cycles after it is taken
    always @(posedge clk) begin
        cycle++;
        av_rsp_valid <= 1'b0;
        if (rst_n && av_req_valid && av_req_ready) begin
            if (av_req.wr) begin
                regs[av_req.addr[5:0]] = av_req.wdata;
            end else begin
                due = cycle + ($unsigned($random(seed)) % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rsp_data.push_back(regs[av_req.addr[5:0]]);
                rsp_due.push_back(due);
            end
        end
        if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
            av_rsp_valid <= 1'b1;
            av_rsp.rdata <= rsp_data.pop_front();
            void'(rsp_due.pop_front());
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================

    function automatic logic [`HC_ADDR_W-1:0] random_addr();
        return $random(seed) & 32'hFFFF_FFF8;
    endfunction

    // Holds the beat until ready is seen at a falling edge, then drops it after the transfer
    task automatic issue_read(input logic [`HC_ADDR_W-1:0] addr);
        @(posedge clk);
        rd_req_valid <= 1'b1;
        rd_req.addr  <= addr;
        @(negedge clk);
        while (!rd_req_ready) @(negedge clk);
        @(posedge clk);
        rd_req_valid <= 1'b0;
    endtask

    task automatic issue_mmio(input logic wr, input logic [15:0] addr,
                              input logic [`HC_DATA_W-1:0] data);
        @(posedge clk);
        mmio_in_valid <= 1'b1;
        mmio_in.wr    <= wr;
        mmio_in.tid   <= next_tid;
        mmio_in.addr  <= addr;
        mmio_in.data  <= data;
        next_tid = next_tid + 1'b1;
        @(negedge clk);
        while (!mmio_in_ready) @(negedge clk);
        @(posedge clk);
        mmio_in_valid <= 1'b0;
    endtask

    task automatic idle_gap();
        repeat ($unsigned($random(seed)) % 4) @(posedge clk);
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (!drained) @(negedge clk);
    endtask

    task automatic close_run(input bit timed_out);
        $display("errors: value=%0d protocol=%0d timeout=%0d", value_errs, proto_errs,
                 timed_out);
        if (!timed_out && value_errs == 0 && proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        rst_n         = 1'b0;
        rd_req_valid  = 1'b0;
        rd_req        = '0;
        rd_rsp_ready  = 1'b0;
        host_rx_valid = 1'b0;
        host_rx       = '0;
        mmio_in_valid = 1'b0;
        mmio_in       = '0;
        host_tx_ready = 1'b0;
        av_req_ready  = 1'b0;
        av_rsp_valid  = 1'b0;
        av_rsp        = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Shuffled host replies must still come back in issue order
        repeat (N_P1) issue_read(random_addr());
        wait_drained();

        // Host silent, so the ninth read has to wait for a free tag
        hold_replies = 1'b1;
        fork
            repeat (N_P2) issue_read(random_addr());
            begin
                repeat (40) @(posedge clk);
                hold_replies <= 1'b0;
            end
        join
        wait_drained();

        // Fill sixteen registers, then read each back
        for (int i = 0; i < N_P3 / 2; i++) begin
            issue_mmio(1'b1, 16'(i), {$random(seed), $random(seed)});
        end
        for (int i = 0; i < N_P3 / 2; i++) begin
            issue_mmio(1'b0, 16'(i), '0);
        end
        wait_drained();

        // Both sources busy with random stalls on every output
        stall_outputs = 1'b1;
        fork
            repeat (N_P4 / 2) begin
                idle_gap();
                issue_read(random_addr());
            end
            repeat (N_P4 / 2) begin
                idle_gap();
                issue_mmio(1'($random(seed)), 16'($unsigned($random(seed)) % 16),
                           {$random(seed), $random(seed)});
            end
        join
        wait_drained();
        close_run(1'b0);
    end

    // Watchdog
    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        $display("timeout: traffic did not drain within %0d cycles", WD_LIMIT);
        close_run(1'b1);
    end

endmodule
